//--- cache_controller.sv
module cache_controller #(
	parameter int INDEX_WIDTH = 10
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [27:0]            cache_addr,
	input  logic [31:0]            cache_wr,
	input  logic                   cache_rw,
	input  logic                   cache_valid,
	input  logic                   flush,
	output logic [31:0]            cache_rd,
	output logic                   cache_ready,
	output logic [27:0]            mem_addr,
	output cache_pkg::cache_line_u mem_wr,
	output logic                   mem_rw,
	output logic                   mem_valid,
	input  cache_pkg::cache_line_u mem_rd,
	input  logic                   mem_ready,
	output logic [27:0]            io_addr,
	output logic [31:0]            io_wr,
	output logic                   io_rw,
	output logic                   io_valid,
	input  logic [31:0]            io_rd,
	input  logic                   io_ready,
	cache_way_if.ctrl              ways [2]
);
	import cache_pkg::*;

	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
	localparam int NUM_SETS  = 1 << INDEX_WIDTH;

	// --------------------
	// Declarations
	// --------------------
	cache_state_e              state, next_state;

	logic [TAG_WIDTH-1:0]      addr_tag;
	logic [INDEX_WIDTH-1:0]    addr_index;
	logic [OFFSET_WIDTH-1:0]   addr_offset;
	logic                      is_io;
	logic                      req_go;

	// Way read-back pulled out of the interface array
	logic                      way_hit   [2];
	logic                      way_valid [2];
	logic                      way_dirty [2];
	logic [TAG_WIDTH-1:0]      way_tag   [2];
	cache_line_u               way_data  [2];
	logic [1:0]                way_we;

	logic                      hit;
	logic                      hit_way;
	logic                      tag_matched;
	cache_line_u               hit_line;
	cache_line_u               merged_line;
	cache_line_u               line_wr;
	logic [INDEX_WIDTH-1:0]    way_index;

	logic [NUM_SETS-1:0]       lru;         // Way to replace next in each set
	logic                      victim;
	logic                      victim_q;
	logic                      victim_dirty;
	logic                      wb_way;

	logic                      flush_flag;
	logic [INDEX_WIDTH:0]      flush_cnt;   // {set, way}
	logic [INDEX_WIDTH-1:0]    flush_set;
	logic                      flush_way;
	logic                      flush_dirty;
	logic                      flush_step;
	logic                      flush_clean;
	logic                      flush_last;

	logic                      cache_ready_q;
	logic [WORD_WIDTH-1:0]     cache_rd_q;

	// Address split into tag, index and offset
	assign addr_tag    = cache_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
	assign addr_index  = cache_addr[OFFSET_WIDTH +: INDEX_WIDTH];
	assign addr_offset = word_offset(cache_addr);
	assign is_io       = cache_addr[IO_BIT];

	// No new request while the ready pulse is still out
	assign req_go = cache_valid & ~cache_ready_q & ~is_io;

	assign flush_set = flush_cnt[INDEX_WIDTH:1];
	assign flush_way = flush_cnt[0];
	assign way_index = flush_flag ? flush_set : addr_index;

	// --------------------
	// Way connections
	// --------------------
	for (genvar g = 0; g < 2; g++) begin : gen_way_bus
		assign way_hit[g]   = ways[g].hit;
		assign way_valid[g] = ways[g].valid_read;
		assign way_dirty[g] = ways[g].dirty_read;
		assign way_tag[g]   = ways[g].tag_read;
		assign way_data[g]  = ways[g].data_read;

		assign way_we[g] = (tag_matched & cache_rw & (hit_way == 1'(g)))
			| ((state == st_allocate) & mem_ready & (victim_q == 1'(g)))
			| (flush_clean & (flush_way == 1'(g)));

		assign ways[g].index       = way_index;
		assign ways[g].tag         = flush_flag ? way_tag[g] : addr_tag; // Flush keeps old tag
		assign ways[g].data_write  = line_wr;
		assign ways[g].dirty_write = tag_matched & cache_rw;
		assign ways[g].write_en    = way_we[g];
	end

	assign hit         = way_hit[0] | way_hit[1];
	assign hit_way     = way_hit[1];
	assign hit_line    = way_data[hit_way];
	assign tag_matched = (state == st_compare) & hit & cache_valid;

	// Write hit merges one word into the line
	always_comb begin
		merged_line = hit_line;
		merged_line.words[addr_offset] = cache_wr;
	end

	always_comb begin
		if (state == st_allocate)
			line_wr.flat = mem_rd.flat;
		else if (flush_flag)
			line_wr = way_data[flush_way]; // Same line rewritten clean
		else
			line_wr = merged_line;
	end

	// --------------------
	// Victim and LRU
	// --------------------
	always_comb begin
		if (!way_valid[0])
			victim = 1'b0;
		else if (!way_valid[1])
			victim = 1'b1;
		else
			victim = lru[addr_index];
	end

	assign victim_dirty = way_valid[victim] & way_dirty[victim];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lru      <= '0;
			victim_q <= 1'b0;
		end else begin
			if (tag_matched)
				lru[addr_index] <= ~hit_way; // Other way goes next
			if ((state == st_compare) && !hit)
				victim_q <= victim;
		end
	end

	// --------------------
	// Flush walk
	// --------------------
	assign flush_dirty = way_valid[flush_way] & way_dirty[flush_way];
	assign flush_step  = (state == st_write_back) & flush_flag & (~flush_dirty | mem_ready);
	assign flush_clean = flush_step & flush_dirty;
	assign flush_last  = flush_step & (&flush_cnt);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flush_flag <= 1'b0;
			flush_cnt  <= '0;
		end else begin
			if (!cache_valid || flush_last)
				flush_flag <= 1'b0;
			else if ((state == st_idle) && req_go && flush)
				flush_flag <= 1'b1;

			if (state == st_idle)
				flush_cnt <= '0;
			else if (flush_step)
				flush_cnt <= flush_cnt + 1'b1;
		end
	end

	// --------------------
	// FSM
	// --------------------
	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (req_go)
					next_state = flush ? st_write_back : st_compare;
			end
			st_compare: begin
				if (hit)
					next_state = st_idle;
				else if (victim_dirty)
					next_state = st_write_back;
				else
					next_state = st_allocate;
			end
			st_write_back: begin
				if (flush_flag) begin
					if (flush_last)
						next_state = st_idle;
				end else if (mem_ready) begin
					next_state = st_allocate;
				end
			end
			st_allocate: begin
				if (mem_ready)
					next_state = st_compare; // Compare again and hit
			end
			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= st_idle;
		else if (!cache_valid)
			state <= st_idle; // Request withdrawn
		else
			state <= next_state;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cache_ready_q <= 1'b0;
		else
			cache_ready_q <= tag_matched | flush_last;
	end

	always_ff @(posedge clk) begin
		if (tag_matched && !cache_rw)
			cache_rd_q <= hit_line.words[addr_offset];
	end

	// --------------------
	// Memory port
	// --------------------
	assign wb_way = flush_flag ? flush_way : victim_q;

	always_comb begin
		mem_addr = '0;
		if (state == st_write_back)
			mem_addr = {way_tag[wb_way], way_index, {OFFSET_WIDTH{1'b0}}}; // Stored tag
		else if (state == st_allocate)
			mem_addr = line_base(cache_addr);
	end

	assign mem_wr    = (state == st_write_back) ? way_data[wb_way] : '0;
	assign mem_rw    = (state == st_write_back);
	assign mem_valid = (state == st_allocate)
		| ((state == st_write_back) & (~flush_flag | flush_dirty));

	// Purely combinational IO bypass
	assign io_addr     = is_io ? cache_addr : '0;
	assign io_wr       = is_io ? cache_wr : '0;
	assign io_rw       = is_io & cache_rw;
	assign io_valid    = is_io & cache_valid;
	assign cache_rd    = is_io ? io_rd : cache_rd_q;
	assign cache_ready = is_io ? io_ready : cache_ready_q;

	// --------------------
	// Checks
	// --------------------
	a_ready_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		cache_ready |=> !cache_ready
	);

	a_one_way_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(way_we)
	);

	// IO space never reaches memory
	a_io_no_mem: assert property (
		@(posedge clk) disable iff (!rst_n)
		(cache_valid && is_io) |-> !mem_valid
	);

endmodule

//--- cache_pkg.sv
package cache_pkg;

	// --------------------
	// Address and data widths
	// --------------------
	localparam int ADDR_WIDTH     = 28;
	localparam int WORD_WIDTH     = 32;
	localparam int LINE_WIDTH     = 256;
	localparam int WORDS_PER_LINE = LINE_WIDTH / WORD_WIDTH;
	localparam int OFFSET_WIDTH   = 3;  // Word offset inside a line
	localparam int IO_BIT         = 27; // Uncached IO space select

	// One cache line, seen flat or word by word
	typedef union packed {
		logic [LINE_WIDTH-1:0]                     flat;
		logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] words;
	} cache_line_u;

	// Controller FSM states
	typedef enum logic [1:0] {
		st_idle       = 2'b00,
		st_compare    = 2'b01,
		st_write_back = 2'b10,
		st_allocate   = 2'b11
	} cache_state_e;

	// --------------------
	// Offset helpers
	// --------------------
	function automatic logic [OFFSET_WIDTH-1:0] word_offset(
		input logic [ADDR_WIDTH-1:0] addr
	);
		return addr[OFFSET_WIDTH-1:0];
	endfunction

	// Line address with the word offset cleared
	function automatic logic [ADDR_WIDTH-1:0] line_base(
		input logic [ADDR_WIDTH-1:0] addr
	);
		return {addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
	endfunction

endpackage

//--- cache_subsystem.f
cache_pkg.sv
cache_way_if.sv
cache_way.sv
cache_controller.sv
cache_subsystem.sv
tb_mem_model.sv
tb_cache_subsystem.sv

//--- cache_subsystem.sv
module cache_subsystem #(
	parameter int INDEX_WIDTH = 10
) (
	input  logic         clk,
	input  logic         rst_n,

	// Processor side
	input  logic [27:0]  cache_addr,
	input  logic [31:0]  cache_wr,
	input  logic         cache_rw,
	input  logic         cache_valid,
	input  logic         flush,
	output logic [31:0]  cache_rd,
	output logic         cache_ready,

	// Main memory, one line per transfer
	output logic [27:0]  mem_addr,
	output logic [255:0] mem_wr,
	output logic         mem_rw,
	output logic         mem_valid,
	input  logic [255:0] mem_rd,
	input  logic         mem_ready,

	// Uncached IO space
	output logic [27:0]  io_addr,
	output logic [31:0]  io_wr,
	output logic         io_rw,
	output logic         io_valid,
	input  logic [31:0]  io_rd,
	input  logic         io_ready
);

	// One bus per way
	cache_way_if #(.INDEX_WIDTH(INDEX_WIDTH)) way_bus [2] ();

	// --------------------
	// Storage ways
	// --------------------
	for (genvar g = 0; g < 2; g++) begin : gen_way
		cache_way #(
			.INDEX_WIDTH(INDEX_WIDTH)
		) i_cache_way (
			.clk   (clk),
			.rst_n (rst_n),
			.bus   (way_bus[g].way)
		);
	end

	cache_controller #(
		.INDEX_WIDTH(INDEX_WIDTH)
	) i_cache_controller (
		.clk         (clk),
		.rst_n       (rst_n),
		.cache_addr  (cache_addr),
		.cache_wr    (cache_wr),
		.cache_rw    (cache_rw),
		.cache_valid (cache_valid),
		.flush       (flush),
		.cache_rd    (cache_rd),
		.cache_ready (cache_ready),
		.mem_addr    (mem_addr),
		.mem_wr      (mem_wr),
		.mem_rw      (mem_rw),
		.mem_valid   (mem_valid),
		.mem_rd      (mem_rd),
		.mem_ready   (mem_ready),
		.io_addr     (io_addr),
		.io_wr       (io_wr),
		.io_rw       (io_rw),
		.io_valid    (io_valid),
		.io_rd       (io_rd),
		.io_ready    (io_ready),
		.ways        (way_bus)
	);

endmodule

//--- cache_way.sv
module cache_way #(
	parameter int INDEX_WIDTH = 10
) (
	input logic       clk,
	input logic       rst_n,
	cache_way_if.way  bus
);
	import cache_pkg::*;

	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
	localparam int NUM_SETS  = 1 << INDEX_WIDTH;

	// --------------------
	// Storage arrays
	// --------------------
	logic [TAG_WIDTH-1:0]  tag_mem  [NUM_SETS];
	logic [LINE_WIDTH-1:0] line_mem [NUM_SETS];
	logic [NUM_SETS-1:0]   valid_mem;
	logic [NUM_SETS-1:0]   dirty_mem;

	logic                  tag_match;

	// Status bits, cleared on reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_mem <= '0;
			dirty_mem <= '0;
		end else if (bus.write_en) begin
			valid_mem[bus.index] <= 1'b1; // Any write leaves the line valid
			dirty_mem[bus.index] <= bus.dirty_write;
		end
	end

	// Tag and line payload
	always_ff @(posedge clk) begin
		if (bus.write_en) begin
			tag_mem[bus.index]  <= bus.tag;
			line_mem[bus.index] <= bus.data_write.flat;
		end
	end

	// --------------------
	// Read port and compare
	// --------------------
	assign bus.valid_read = valid_mem[bus.index];
	assign bus.dirty_read = dirty_mem[bus.index];
	assign bus.tag_read   = tag_mem[bus.index];
	assign bus.data_read  = line_mem[bus.index];

	assign tag_match = (bus.tag_read == bus.tag);
	assign bus.hit   = bus.valid_read & tag_match; // Stale tags never hit

	// Set select must be known when a write lands
	a_index_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		bus.write_en |-> !$isunknown(bus.index)
	);

endmodule

//--- cache_way_if.sv
interface cache_way_if #(
	parameter int INDEX_WIDTH = 10
);
	import cache_pkg::*;

	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

	// Controller side
	logic [INDEX_WIDTH-1:0] index;
	logic [TAG_WIDTH-1:0]   tag;
	cache_line_u            data_write;
	logic                   dirty_write;
	logic                   write_en;

	// Way side, all combinational from index
	logic                   hit;
	logic                   valid_read;
	logic                   dirty_read;
	logic [TAG_WIDTH-1:0]   tag_read;
	cache_line_u            data_read;

	modport ctrl (
		output index, tag, data_write, dirty_write, write_en,
		input  hit, valid_read, dirty_read, tag_read, data_read
	);

	modport way (
		input  index, tag, data_write, dirty_write, write_en,
		output hit, valid_read, dirty_read, tag_read, data_read
	);

endinterface

//--- tb_cache_subsystem.sv
module tb_cache_subsystem;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int          INDEX_WIDTH = 2;
	localparam int          NUM_SETS    = 1 << INDEX_WIDTH;
	localparam int          TAG_WIDTH   = 28 - INDEX_WIDTH - 3;
	localparam int          TIMEOUT     = 200;
	localparam logic [31:0] PATTERN     = 32'h5a3c_96e1;

	localparam logic [2:0] K_READ     = 3'd0;
	localparam logic [2:0] K_WRITE    = 3'd1;
	localparam logic [2:0] K_IO_READ  = 3'd2;
	localparam logic [2:0] K_IO_WRITE = 3'd3;
	localparam logic [2:0] K_FLUSH    = 3'd4;

	typedef struct packed {
		logic [2:0]  kind;
		logic [27:0] addr;
		logic [31:0] wdata;
		logic [31:0] iodata; // Returned by the IO device
	} step_t;

	logic         clk = 1'b0;
	logic         rst_n;
	logic [27:0]  cache_addr;
	logic [31:0]  cache_wr;
	logic         cache_rw;
	logic         cache_valid;
	logic         flush;
	logic [31:0]  cache_rd;
	logic         cache_ready;
	logic [27:0]  mem_addr;
	logic [255:0] mem_wr;
	logic         mem_rw;
	logic         mem_valid;
	logic [255:0] mem_rd;
	logic         mem_ready;
	logic [27:0]  io_addr;
	logic [31:0]  io_wr;
	logic         io_rw;
	logic         io_valid;
	logic [31:0]  io_rd;
	logic         io_ready;
	int           write_count;

	step_t                steps [$];
	logic [31:0]          shadow [int]; // Words written so far
	logic [TAG_WIDTH-1:0] ref_tag   [NUM_SETS][2];
	bit                   ref_valid [NUM_SETS][2];
	bit                   ref_dirty [NUM_SETS][2];
	bit                   ref_lru   [NUM_SETS];
	int                   exp_writes;
	int                   errors;
	int                   checks;

	always #4 clk = ~clk;

	cache_subsystem #(.INDEX_WIDTH(INDEX_WIDTH)) i_cache_subsystem (.*);

	tb_mem_model #(.PATTERN(PATTERN)) i_mem_model (.*);

	// --------------------
	// Helpers
	// --------------------
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic end_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	endtask

	task automatic wait_ready(output int cycles, output bit ok);
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!cache_ready && cycles < TIMEOUT);
		ok = cache_ready;
		if (!ok) begin
			errors++;
			$display("timeout: cache_ready never came within %0d cycles", TIMEOUT);
		end
	endtask

	task automatic drive_request(input logic [27:0] addr, input logic [31:0] wdata,
		input logic rw, input logic fl);
		@(posedge clk);
		cache_addr  <= addr;
		cache_wr    <= wdata;
		cache_rw    <= rw;
		flush       <= fl;
		cache_valid <= 1'b1;
	endtask

	task automatic release_request();
		cache_valid <= 1'b0;
		flush       <= 1'b0;
		io_ready    <= 1'b0;
	endtask

	function automatic logic [31:0] expected_word(input logic [27:0] addr);
		if (shadow.exists(int'(addr)))
			return shadow[int'(addr)];
		return 32'(addr) ^ PATTERN;
	endfunction

	// Reference tags that pick an invalid way first and then the LRU way of the set
	task automatic ref_access(input logic [27:0] addr, input bit is_write, output bit hit);
		int                   set;
		int                   way;
		logic [TAG_WIDTH-1:0] tag;
		set = addr[3 +: INDEX_WIDTH];
		tag = addr[27 -: TAG_WIDTH];
		way = -1;
		for (int w = 0; w < 2; w++)
			if (ref_valid[set][w] && ref_tag[set][w] == tag)
				way = w;
		hit = (way >= 0);
		if (!hit) begin
			if (!ref_valid[set][0])
				way = 0;
			else if (!ref_valid[set][1])
				way = 1;
			else
				way = ref_lru[set];
			if (ref_dirty[set][way])
				exp_writes++; // Victim goes back to memory
			ref_valid[set][way] = 1'b1;
			ref_tag[set][way]   = tag;
			ref_dirty[set][way] = 1'b0;
		end
		if (is_write)
			ref_dirty[set][way] = 1'b1;
		ref_lru[set] = (way == 0);
	endtask

	// --------------------
	// Stimulus
	// --------------------
	initial begin
		step_t       s;
		logic [31:0] rd;
		int          cycles;
		int          base;
		int          dirty_lines;
		bit          hit;
		bit          ok;
		rst_n       = 1'b0;
		cache_addr  = '0;
		cache_wr    = '0;
		cache_rw    = 1'b0;
		cache_valid = 1'b0;
		flush       = 1'b0;
		io_rd       = '0;
		io_ready    = 1'b0;
		errors      = 0;
		checks      = 0;
		exp_writes  = 0;

		steps.push_back({K_READ,     28'h000_0000, 32'h0,         32'h0}); // Cold miss
		steps.push_back({K_WRITE,    28'h000_0001, 32'ha5a5_0001, 32'h0});
		steps.push_back({K_READ,     28'h000_0001, 32'h0,         32'h0});
		steps.push_back({K_READ,     28'h000_0005, 32'h0,         32'h0});
		steps.push_back({K_WRITE,    28'h000_0022, 32'h1111_2222, 32'h0});
		steps.push_back({K_WRITE,    28'h000_0043, 32'h3333_4444, 32'h0}); // Third tag in set 0
		steps.push_back({K_READ,     28'h000_0001, 32'h0,         32'h0});
		steps.push_back({K_READ,     28'h000_0022, 32'h0,         32'h0});
		steps.push_back({K_READ,     28'h000_0043, 32'h0,         32'h0});
		steps.push_back({K_IO_WRITE, 28'h800_0010, 32'hdead_beef, 32'h0});
		steps.push_back({K_IO_READ,  28'h800_0024, 32'h0,         32'h1234_abcd});
		steps.push_back({K_WRITE,    28'h000_000d, 32'h0bad_cafe, 32'h0});
		steps.push_back({K_WRITE,    28'h000_07f9, 32'h7777_0001, 32'h0});
		steps.push_back({K_FLUSH,    28'h000_0000, 32'h0,         32'h0});
		steps.push_back({K_READ,     28'h000_000d, 32'h0,         32'h0});
		steps.push_back({K_READ,     28'h000_0043, 32'h0,         32'h0});
		steps.push_back({K_READ,     28'h000_0001, 32'h0,         32'h0});
		steps.push_back({K_READ,     28'h000_07f9, 32'h0,         32'h0});

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_value("cache_ready", cache_ready, 32'h0);
		check_value("mem_valid", mem_valid, 32'h0);
		check_value("io_valid", io_valid, 32'h0);

		foreach (steps[i]) begin
			s = steps[i];
			case (s.kind)
				K_READ, K_WRITE: begin
					ref_access(s.addr, s.kind == K_WRITE, hit);
					drive_request(s.addr, s.wdata, s.kind == K_WRITE, 1'b0);
					wait_ready(cycles, ok);
					if (!ok)
						break;
					rd = cache_rd;
					release_request();
					if (s.kind == K_WRITE)
						shadow[int'(s.addr)] = s.wdata;
					else
						check_value("cache_rd", rd, expected_word(s.addr));
					if (hit)
						check_value("cache_ready delay", cycles - 1, 32'd2);
					check_value("write_count", write_count, exp_writes);
				end
				K_IO_READ, K_IO_WRITE: begin
					drive_request(s.addr, s.wdata, s.kind == K_IO_WRITE, 1'b0);
					@(posedge clk);
					check_value("io_addr", io_addr, s.addr);
					check_value("io_wr", io_wr, s.wdata);
					check_value("io_rw", io_rw, s.kind == K_IO_WRITE);
					check_value("io_valid", io_valid, 32'h1);
					check_value("mem_valid", mem_valid, 32'h0);
					io_rd    <= s.iodata;
					io_ready <= 1'b1;
					wait_ready(cycles, ok);
					if (!ok)
						break;
					check_value("cache_rd", cache_rd, s.iodata);
					check_value("mem_valid", mem_valid, 32'h0);
					release_request();
				end
				default: begin
					dirty_lines = 0;
					for (int st = 0; st < NUM_SETS; st++)
						for (int w = 0; w < 2; w++)
							if (ref_dirty[st][w]) begin
								dirty_lines++;
								ref_dirty[st][w] = 1'b0;
							end
					base = write_count;
					drive_request(s.addr, 32'h0, 1'b0, 1'b1);
					wait_ready(cycles, ok);
					if (!ok)
						break;
					release_request();
					check_value("flush write_count", write_count - base, dirty_lines);
					exp_writes += dirty_lines;
					foreach (shadow[a])
						check_value("memory word", i_mem_model.lines[a >> 3][(a & 7) * 32 +: 32],
							shadow[a]);
				end
			endcase
		end

		end_run();
	end

endmodule

//--- tb_mem_model.sv
module tb_mem_model #(
	parameter logic [31:0] PATTERN = 32'h5a3c_96e1
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic [27:0]  mem_addr,
	input  logic [255:0] mem_wr,
	input  logic         mem_rw,
	input  logic         mem_valid,
	output logic [255:0] mem_rd,
	output logic         mem_ready,
	output int           write_count
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [255:0] lines [256]; // Covers word addresses below 0x800
	logic [7:0]   line_idx;
	logic         busy;
	int           delay;
	int           seed;

	assign line_idx = mem_addr[10:3];

	// Every word starts as its own address XOR the pattern
	initial begin
		seed = 83736;
		for (int l = 0; l < 256; l++)
			for (int w = 0; w < 8; w++)
				lines[l][w*32 +: 32] = (l * 8 + w) ^ PATTERN;
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_ready   <= 1'b0;
			mem_rd      <= '0;
			busy        <= 1'b0;
			delay       <= 0;
			write_count <= 0;
		end else if (mem_ready) begin
			mem_ready <= 1'b0; // Transfer taken at this edge
		end else if (mem_valid && !busy) begin
			busy  <= 1'b1;
			delay <= 1 + {$random(seed)} % 4;
		end else if (busy) begin
			if (delay == 1) begin
				busy      <= 1'b0;
				mem_ready <= 1'b1;
				if (mem_rw) begin
					lines[line_idx] <= mem_wr;
					write_count     <= write_count + 1;
				end else begin
					mem_rd <= lines[line_idx];
				end
			end else begin
				delay <= delay - 1;
			end
		end
	end

endmodule
